// File: dv/smc_lite_chk.sv
// Protocol checks bound into smc_lite, all held off while n_sys_reset16 is low
// Watches the AHB response pair and the external SRAM strobes
`default_nettype none
`timescale 1ns/10ps

module smc_lite_chk (
  input logic                    hclk16,
  input logic                    n_sys_reset16,
  input logic                    smc_hready,
  input logic [1:0]              smc_hresp,
  input logic                    n_cs,
  input logic                    n_oe,
  input logic                    n_we,
  input smc_pkg::access_state_e  state          // Sequencer state
);
  import smc_pkg::*;

  // ------------------------------------------------------------
  // Two-cycle ERROR, ready low then high
  error_second_cycle: assert property (@(posedge hclk16) disable iff (!n_sys_reset16)
    ((smc_hresp == RSP_ERROR) && !smc_hready) |=> ((smc_hresp == RSP_ERROR) && smc_hready))
  else $error("ERROR response with hready low not followed by ERROR with hready high");

  // Never drive and read the SRAM at once
  oe_we_exclusive: assert property (@(posedge hclk16) disable iff (!n_sys_reset16)
    !(!n_oe && !n_we))
  else $error("n_oe and n_we both low");

  cs_high_when_idle: assert property (@(posedge hclk16) disable iff (!n_sys_reset16)
    (state == ST_IDLE) |-> n_cs)
  else $error("n_cs low while the sequencer is idle");

endmodule

bind smc_lite smc_lite_chk smc_lite_chk_inst (
  .hclk16        (hclk16),
  .n_sys_reset16 (n_sys_reset16),
  .smc_hready    (smc_hready),
  .smc_hresp     (smc_hresp),
  .n_cs          (n_cs),
  .n_oe          (n_oe),
  .n_we          (n_we),
  .state         (smc_access_ctrl_inst.state)
);

`default_nettype wire

// File: dv/smc_lite_tb.sv
// Random AHB-Lite traffic against a byte reference model and an 8-bit SRAM model
// hready loops back from smc_hready, this is the only slave on the bus
// Read data is compared in the last data-phase cycle, SRAM content one cycle later
`include "smc_config.svh"
`default_nettype none
`timescale 1ns/10ps

module smc_lite_tb;
  import smc_pkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int NUM_XFERS       = 400;
  localparam int EXT_BYTES       = 1 << `SMC_EXT_AW;
  localparam int XFER_CYCLES     = 1 + 4 * (`SMC_WAIT_STATES + 1) + 2;  // Word access, worst case
  localparam int WATCHDOG_CYCLES = NUM_XFERS * XFER_CYCLES + 100;
  localparam logic [31:0] RAND_SEED = 32'ha31c;

  logic       hclk16 = 1'b0;
  logic       n_sys_reset16;
  haddr_t     haddr;
  logic       hsel;
  logic [1:0] htrans;
  logic       hwrite;
  logic [2:0] hsize;
  hdata_t     hwdata;
  logic       hready;
  hdata_t     smc_hrdata;
  logic       smc_hready;
  logic [1:0] smc_hresp;
  ext_addr_t  ext_addr;
  ext_byte_t  ext_wdata;
  logic       n_cs;
  logic       n_oe;
  logic       n_we;
  ext_byte_t  ext_rdata;

  ext_byte_t  sram [EXT_BYTES];      // Device content
  ext_byte_t  ref_mem [EXT_BYTES];   // Expected content
  int         errors = 0;

  // SRAM word left to check from the previous transfer
  logic       word_pending = 1'b0;
  haddr_t     prev_addr;

  always #(CLK_PERIOD / 2) hclk16 = ~hclk16;

  assign hready = smc_hready;        // Single slave, no bus mux

  // ------------------------------------------------------------
  // SRAM model, read path combinational
  assign ext_rdata = (!n_cs && !n_oe) ? sram[ext_addr] : '0;

  always @(posedge hclk16)
  begin
    if (!n_sys_reset16)
      for (int i = 0; i < EXT_BYTES; i++)
        sram[ext_addr_t'(i)] <= fill_byte(ext_addr_t'(i));  // Power-up content
    else if (!n_cs && !n_we)
      sram[ext_addr] <= ext_wdata;
  end

  smc_lite smc_lite_inst (
    .hclk16        (hclk16),
    .n_sys_reset16 (n_sys_reset16),
    .haddr         (haddr),
    .hsel          (hsel),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hsize         (hsize),
    .hwdata        (hwdata),
    .hready        (hready),
    .smc_hrdata    (smc_hrdata),
    .smc_hready    (smc_hready),
    .smc_hresp     (smc_hresp),
    .ext_addr      (ext_addr),
    .ext_wdata     (ext_wdata),
    .n_cs          (n_cs),
    .n_oe          (n_oe),
    .n_we          (n_we),
    .ext_rdata     (ext_rdata)
  );

  // Depends on every address bit
  function automatic ext_byte_t fill_byte(input ext_addr_t a);
    return 8'(a) ^ 8'(a >> 2) ^ 8'h5a;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // Touched word of the SRAM
  task automatic check_previous();
    ext_addr_t wa;
    if (word_pending)
      for (int k = 0; k < 4; k++)
      begin
        wa = {prev_addr[`SMC_EXT_AW-1:2], 2'(k)};
        check_val($sformatf("sram[%0h]", wa), 32'(ref_mem[wa]), 32'(sram[wa]));
      end
    word_pending = 1'b0;
  endtask

  // ------------------------------------------------------------
  // One AHB transfer, entered and left just after a rising edge
  task automatic run_transfer(input logic s, input logic [1:0] t, input logic w,
                              input logic [2:0] z, input haddr_t a, input hdata_t wd);
    logic      active;
    logic      misal;
    int        nbytes;
    int        wait_cycles;
    lane_t     ln;
    ext_addr_t ea;
    hdata_t    rd_expect;
    hdata_t    rd_mask;

    active = s && ((t == TRN_NONSEQ) || (t == TRN_SEQ));
    misal  = active && (((z == SZ_HALF) && a[0]) || ((z == SZ_WORD) && (a[1:0] != 2'b00)));
    nbytes = 1 << z;
    hsel   <= s;                     // Address phase
    htrans <= t;
    hwrite <= w;
    hsize  <= z;
    haddr  <= a;
    @(negedge hclk16);
    check_previous();
    @(posedge hclk16);
    hsel   <= 1'b0;                  // Bus idle during the data phase
    htrans <= TRN_IDLE;
    hwdata <= wd;
    @(negedge hclk16);
    if (!active)
    begin
      check_val("smc_hready", 32'(1), 32'(smc_hready));  // Zero-wait OKAY
      check_val("smc_hresp", 32'(RSP_OKAY), 32'(smc_hresp));
      check_val("n_cs", 32'(1), 32'(n_cs));
    end
    else if (misal)
    begin
      check_val("smc_hready", 32'(0), 32'(smc_hready));
      check_val("smc_hresp", 32'(RSP_ERROR), 32'(smc_hresp));
      check_val("n_cs", 32'(1), 32'(n_cs));
      @(negedge hclk16);
      check_val("smc_hready", 32'(1), 32'(smc_hready));
      check_val("smc_hresp", 32'(RSP_ERROR), 32'(smc_hresp));
      check_val("n_cs", 32'(1), 32'(n_cs));
    end
    else
    begin
      wait_cycles = 0;
      while (!smc_hready)
      begin
        check_val("smc_hresp", 32'(RSP_OKAY), 32'(smc_hresp));
        if (w)
          check_val("n_oe", 32'(1), 32'(n_oe));
        else
          check_val("n_we", 32'(1), 32'(n_we));
        wait_cycles++;
        @(negedge hclk16);
      end
      assert (wait_cycles > 0)
      else
      begin
        $display("Valid access to %h finished without any wait state", a);
        errors++;
      end
      check_val("smc_hresp", 32'(RSP_OKAY), 32'(smc_hresp));
      rd_expect = '0;
      rd_mask   = '0;
      for (int k = 0; k < nbytes; k++)
      begin
        ln = a[1:0] + 2'(k);         // Little-endian lane
        ea = a[`SMC_EXT_AW-1:0] + ext_addr_t'(k);
        if (w)
          ref_mem[ea] = wd[{ln, 3'b000} +: 8];
        else
        begin
          rd_expect[{ln, 3'b000} +: 8] = ref_mem[ea];
          rd_mask[{ln, 3'b000} +: 8]   = 8'hff;
        end
      end
      if (!w)                        // Final data-phase cycle
        check_val("smc_hrdata", rd_expect & rd_mask, smc_hrdata & rd_mask);
    end
    prev_addr    = a;
    word_pending = 1'b1;
    @(posedge hclk16);               // Completing edge
  endtask

  // ------------------------------------------------------------
  // Stimulus
  initial
  begin
    logic       s;
    logic [1:0] t;
    logic       w;
    logic [2:0] z;
    haddr_t     a;
    hdata_t     wd;
    int         pick;
    haddr_t     last_addr;
    logic       have_last;

    void'($urandom(RAND_SEED));
    n_sys_reset16 = 1'b0;
    haddr         = '0;
    hsel          = 1'b0;
    htrans        = TRN_IDLE;
    hwrite        = 1'b0;
    hsize         = SZ_BYTE;
    hwdata        = '0;
    have_last     = 1'b0;
    last_addr     = '0;
    for (int i = 0; i < EXT_BYTES; i++)
      ref_mem[ext_addr_t'(i)] = fill_byte(ext_addr_t'(i));

    repeat (2) @(posedge hclk16);
    n_sys_reset16 <= 1'b1;
    @(negedge hclk16);
    check_val("smc_hready", 32'(1), 32'(smc_hready));   // Reset values
    check_val("smc_hresp", 32'(RSP_OKAY), 32'(smc_hresp));
    check_val("n_cs", 32'(1), 32'(n_cs));
    check_val("n_oe", 32'(1), 32'(n_oe));
    check_val("n_we", 32'(1), 32'(n_we));
    @(posedge hclk16);

    for (int n = 0; n < NUM_XFERS; n++)
    begin
      s    = ($urandom_range(0, 7) != 0);
      pick = $urandom_range(0, 9);
      t    = (pick == 0) ? TRN_IDLE : (pick == 1) ? TRN_BUSY :
             (pick < 6) ? TRN_NONSEQ : TRN_SEQ;
      w    = 1'($urandom_range(0, 1));
      z    = 3'($urandom_range(0, 2));
      if (have_last && ($urandom_range(0, 1) == 1))
        a = last_addr;               // Revisit a written word
      else
        a = $urandom_range(0, EXT_BYTES - 1);
      if ($urandom_range(0, 3) != 0) // Mostly aligned
      begin
        if (z == SZ_HALF)
          a[0] = 1'b0;
        else if (z == SZ_WORD)
          a[1:0] = 2'b00;
      end
      wd = $urandom();
      run_transfer(s, t, w, z, a, wd);
      if (s && w && ((t == TRN_NONSEQ) || (t == TRN_SEQ)))
      begin
        last_addr = a;
        have_last = 1'b1;
      end
    end

    @(negedge hclk16);
    check_previous();
    $display("Ran %0d transfers, %0d errors", NUM_XFERS, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, %0d errors so far", WATCHDOG_CYCLES, errors);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the smc_lite testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f smc_lite.f --top-module smc_lite_tb
status=0
./obj_dir/Vsmc_lite_tb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Testbench failed" sim.log; then
  echo "Simulation result: FAIL"
  exit 1
fi
echo "Simulation result: PASS"

// File: smc_lite.f
+incdir+src
src/smc_pkg.sv
src/smc_ahb_if.sv
src/smc_access_ctrl.sv
src/smc_mem_port.sv
src/smc_lite.sv
dv/smc_lite_chk.sv
dv/smc_lite_tb.sv

// File: src/smc_access_ctrl.sv
// Byte access sequencer, splits one AHB transfer into 1, 2 or 4 byte accesses
// Each byte takes SMC_WAIT_STATES cycles in ST_STROBE plus one in ST_NEXT or ST_DONE
// strobe leads the external pins by one cycle, as the memory port registers them
`include "smc_config.svh"
`default_nettype none
`timescale 1ns/10ps

module smc_access_ctrl (
  input  logic                 hclk16,
  input  logic                 n_sys_reset16,
  input  logic                 new_access,    // Start of a transfer
  input  smc_pkg::xfer_size_t  xfer_size,
  input  smc_pkg::lane_t       start_lane,    // addr[1:0] of the transfer
  output logic                 smc_idle,
  output logic                 smc_done,      // Last cycle of a byte access
  output logic                 mac_done,      // Current byte is the final one
  output logic                 strobe,        // External access request
  output smc_pkg::lane_t       lane           // Current byte index
);
  import smc_pkg::*;

  localparam int WCNT_W = $clog2(`SMC_WAIT_STATES + 1);
  localparam logic [WCNT_W-1:0] WAIT_LAST = WCNT_W'(`SMC_WAIT_STATES);
  localparam logic [WCNT_W-1:0] WAIT_FIRST = WCNT_W'(1);

  access_state_e     state;
  access_state_e     next_state;
  logic [WCNT_W-1:0] wait_cnt;     // Cycles spent in ST_STROBE
  logic [1:0]        remain;       // Bytes left after the current one
  logic [1:0]        first_remain;

  // Bytes after the first, per size code
  always_comb
  begin
    case (xfer_size)
      SZ_HALF[1:0]: first_remain = 2'd1;
      SZ_WORD[1:0]: first_remain = 2'd3;
      default:      first_remain = 2'd0;   // Byte
    endcase
  end

  // ------------------------------------------------------------
  // Next state
  always_comb
  begin
    next_state = state;
    case (state)
      ST_IDLE:
        if (new_access)
          next_state = ST_STROBE;
      ST_STROBE:
        if (wait_cnt == WAIT_LAST)
          next_state = mac_done ? ST_DONE : ST_NEXT;
      ST_NEXT:
        next_state = ST_STROBE;  // Pins released for one cycle
      ST_DONE:
        next_state = ST_IDLE;    // hready high this cycle
      default:
        next_state = ST_IDLE;
    endcase
  end

  // ------------------------------------------------------------
  // State, counters and lane
  always_ff @(posedge hclk16 or negedge n_sys_reset16)
  begin
    if (!n_sys_reset16)
    begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
      remain   <= '0;
      lane     <= '0;
    end
    else
    begin
      state <= next_state;
      case (state)
        ST_IDLE:
          if (new_access)
          begin
            remain   <= first_remain;
            lane     <= start_lane;
            wait_cnt <= WAIT_FIRST;
          end
        ST_STROBE:
          if (wait_cnt != WAIT_LAST)
            wait_cnt <= wait_cnt + 1'b1;
        ST_NEXT:
        begin
          remain   <= remain - 2'd1;
          lane     <= lane + 2'd1;     // Rising address order
          wait_cnt <= WAIT_FIRST;
        end
        default:
          wait_cnt <= wait_cnt;
      endcase
    end
  end

  assign smc_idle = (state == ST_IDLE);
  assign smc_done = (state == ST_NEXT) || (state == ST_DONE);
  assign mac_done = (remain == 2'd0);
  assign strobe   = (state == ST_STROBE);

endmodule

`default_nettype wire

// File: src/smc_ahb_if.sv
// AHB-Lite slave front end of the static memory controller
// hready is expected to be the muxed bus ready, smc_hready when this is the only slave
// SEQ beats are taken like NONSEQ, no SPLIT or RETRY
`default_nettype none
`timescale 1ns/10ps

module smc_ahb_if (
  input  logic                 hclk16,        // AHB clock
  input  logic                 n_sys_reset16, // Async reset, active low
  input  smc_pkg::haddr_t      haddr,
  input  logic                 hsel,
  input  logic [1:0]           htrans,
  input  logic                 hwrite,
  input  logic [2:0]           hsize,
  input  smc_pkg::hdata_t      hwdata,
  input  logic                 hready,        // Bus ready in
  input  logic                 smc_idle,      // Sequencer idle
  input  logic                 smc_done,      // Last cycle of a byte strobe
  input  logic                 mac_done,      // Current byte is the final one
  input  smc_pkg::hdata_t      read_data,     // Assembled read word
  output smc_pkg::hdata_t      smc_hrdata,
  output logic                 smc_hready,
  output logic [1:0]           smc_hresp,
  output logic                 new_access,    // First data-phase cycle pulse
  output smc_pkg::haddr_t      addr,
  output smc_pkg::xfer_size_t  xfer_size,
  output logic                 n_read,        // Low for a read
  output smc_pkg::hdata_t      write_data
);
  import smc_pkg::*;

  logic trans_act;   // NONSEQ or SEQ
  logic ctrl_free;   // Sequencer can take a new transfer
  logic mis_err;     // Misaligned half or word
  logic valid;       // Accepted address phase
  logic r_ready;     // Registered ready level
  logic err_pend;    // Second ERROR cycle due

  // ------------------------------------------------------------
  // Address phase decode
  assign trans_act = (htrans == TRN_NONSEQ) || (htrans == TRN_SEQ);
  assign ctrl_free = smc_idle || (smc_done && mac_done);

  assign mis_err = hsel && hready && trans_act &&
                   (((hsize == SZ_HALF) && haddr[0]) ||
                    ((hsize == SZ_WORD) && (haddr[1:0] != 2'b00)));

  assign valid = hsel && hready && trans_act && !mis_err && ctrl_free;

  // Control captured for the data phase
  always_ff @(posedge hclk16)
  begin
    if (valid)
    begin
      addr      <= haddr;
      xfer_size <= hsize[1:0];
      n_read    <= hwrite;        // High means write
    end
    if (new_access)
      write_data <= hwdata;       // hwdata valid in first data cycle
  end

  always_ff @(posedge hclk16 or negedge n_sys_reset16)
  begin
    if (!n_sys_reset16)
      new_access <= 1'b0;
    else
      new_access <= valid;        // One cycle after address phase
  end

  // ------------------------------------------------------------
  // Ready and response
  always_ff @(posedge hclk16 or negedge n_sys_reset16)
  begin
    if (!n_sys_reset16)
    begin
      r_ready   <= 1'b1;
      err_pend  <= 1'b0;
      smc_hresp <= RSP_OKAY;
    end
    else
    begin
      if (valid || mis_err)
        r_ready <= 1'b0;          // Wait state or first ERROR cycle
      else if (smc_hready || err_pend)
        r_ready <= 1'b1;          // Transfer done, or second ERROR cycle
      if (mis_err)
      begin
        err_pend  <= 1'b1;
        smc_hresp <= RSP_ERROR;
      end
      else if (err_pend)
      begin
        err_pend  <= 1'b0;
        smc_hresp <= RSP_ERROR;   // Held with ready high
      end
      else
        smc_hresp <= RSP_OKAY;
    end
  end

  assign smc_hready = r_ready || (smc_done && mac_done);
  assign smc_hrdata = read_data;

endmodule

`default_nettype wire

// File: src/smc_config.svh
// Build-time constants for the static memory controller
// SMC_WAIT_STATES must be 1 or more, as a byte access needs one pin setup cycle
// The external device is a single 8-bit SRAM with no bank select
`ifndef SMC_CONFIG_SVH
`define SMC_CONFIG_SVH

// External byte address width, 1 KB device
`define SMC_EXT_AW 10

// Extra cycles per external strobe
`define SMC_WAIT_STATES 2

// AHB data bus width
`define SMC_HDATA_W 32

// External data bus width, byte lanes assume 8
`define SMC_EXT_DW 8

`endif

// File: src/smc_lite.sv
// Static memory controller top, AHB-Lite slave to one 8-bit async SRAM
// One access in flight at a time, back-pressure only through smc_hready
`default_nettype none
`timescale 1ns/10ps

module smc_lite (
  input  logic                 hclk16,
  input  logic                 n_sys_reset16,
  // AHB side
  input  smc_pkg::haddr_t      haddr,
  input  logic                 hsel,
  input  logic [1:0]           htrans,
  input  logic                 hwrite,
  input  logic [2:0]           hsize,
  input  smc_pkg::hdata_t      hwdata,
  input  logic                 hready,
  output smc_pkg::hdata_t      smc_hrdata,
  output logic                 smc_hready,
  output logic [1:0]           smc_hresp,
  // External bus
  output smc_pkg::ext_addr_t   ext_addr,
  output smc_pkg::ext_byte_t   ext_wdata,
  output logic                 n_cs,
  output logic                 n_oe,
  output logic                 n_we,
  input  smc_pkg::ext_byte_t   ext_rdata
);
  import smc_pkg::*;

  // ------------------------------------------------------------
  // Inter-block wires
  logic       new_access;
  haddr_t     addr;
  xfer_size_t xfer_size;
  logic       n_read;
  hdata_t     write_data;
  hdata_t     read_data;
  logic       smc_idle;
  logic       smc_done;
  logic       mac_done;
  logic       strobe;
  lane_t      lane;

  smc_ahb_if smc_ahb_if_inst (
    .hclk16        (hclk16),
    .n_sys_reset16 (n_sys_reset16),
    .haddr         (haddr),
    .hsel          (hsel),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hsize         (hsize),
    .hwdata        (hwdata),
    .hready        (hready),
    .smc_idle      (smc_idle),
    .smc_done      (smc_done),
    .mac_done      (mac_done),
    .read_data     (read_data),
    .smc_hrdata    (smc_hrdata),
    .smc_hready    (smc_hready),
    .smc_hresp     (smc_hresp),
    .new_access    (new_access),
    .addr          (addr),
    .xfer_size     (xfer_size),
    .n_read        (n_read),
    .write_data    (write_data)
  );

  smc_access_ctrl smc_access_ctrl_inst (
    .hclk16        (hclk16),
    .n_sys_reset16 (n_sys_reset16),
    .new_access    (new_access),
    .xfer_size     (xfer_size),
    .start_lane    (addr[1:0]),     // First byte lane
    .smc_idle      (smc_idle),
    .smc_done      (smc_done),
    .mac_done      (mac_done),
    .strobe        (strobe),
    .lane          (lane)
  );

  smc_mem_port smc_mem_port_inst (
    .hclk16        (hclk16),
    .n_sys_reset16 (n_sys_reset16),
    .addr          (addr),
    .n_read        (n_read),
    .write_data    (write_data),
    .strobe        (strobe),
    .lane          (lane),
    .smc_done      (smc_done),
    .new_access    (new_access),
    .ext_rdata     (ext_rdata),
    .ext_addr      (ext_addr),
    .ext_wdata     (ext_wdata),
    .n_cs          (n_cs),
    .n_oe          (n_oe),
    .n_we          (n_we),
    .read_data     (read_data)
  );

endmodule

`default_nettype wire

// File: src/smc_mem_port.sv
// External SRAM pin driver and read lane assembly
// Strobes are registered from strobe, so pins trail it by one cycle
// ext_addr and ext_wdata follow addr and lane directly
// The byte on ext_rdata passes to read_data while smc_done is high
`include "smc_config.svh"
`default_nettype none
`timescale 1ns/10ps

module smc_mem_port (
  input  logic                 hclk16,
  input  logic                 n_sys_reset16,
  input  smc_pkg::haddr_t      addr,          // Captured AHB address
  input  logic                 n_read,        // Low for a read
  input  smc_pkg::hdata_t      write_data,
  input  logic                 strobe,        // Access request level
  input  smc_pkg::lane_t       lane,          // Current byte index
  input  logic                 smc_done,      // Sample point for read byte
  input  logic                 new_access,    // Clears read_data
  input  smc_pkg::ext_byte_t   ext_rdata,
  output smc_pkg::ext_addr_t   ext_addr,
  output smc_pkg::ext_byte_t   ext_wdata,
  output logic                 n_cs,
  output logic                 n_oe,
  output logic                 n_we,
  output smc_pkg::hdata_t      read_data
);
  import smc_pkg::*;

  logic [4:0] lane_bit;   // Bit offset of the current lane
  hdata_t     rd_word;    // Bytes already returned

  assign lane_bit = {lane, 3'b000};

  // ------------------------------------------------------------
  // External strobes, all high when no access
  always_ff @(posedge hclk16 or negedge n_sys_reset16)
  begin
    if (!n_sys_reset16)
    begin
      n_cs <= 1'b1;
      n_oe <= 1'b1;
      n_we <= 1'b1;
    end
    else
    begin
      n_cs <= !strobe;
      n_oe <= !(strobe && !n_read);   // Read only
      n_we <= !(strobe && n_read);    // Write only
    end
  end

  // Word bits from AHB, byte bits from the sequencer
  assign ext_addr  = {addr[`SMC_EXT_AW-1:2], lane};
  assign ext_wdata = write_data[lane_bit +: `SMC_EXT_DW];

  // ------------------------------------------------------------
  // Read data assembly
  // Unread lanes stay zero for the whole transfer
  always_ff @(posedge hclk16)
  begin
    if (new_access)
      rd_word <= '0;
    else if (smc_done && !n_read)
      rd_word[lane_bit +: `SMC_EXT_DW] <= ext_rdata;  // n_cs, n_oe low here
  end

  // Final byte visible in the last data-phase cycle
  always_comb
  begin
    read_data = rd_word;
    if (smc_done && !n_read)
      read_data[lane_bit +: `SMC_EXT_DW] = ext_rdata;
  end

endmodule

`default_nettype wire

// File: src/smc_pkg.sv
// Shared types and AHB codes for the static memory controller
// Widths come from smc_config.svh
`include "smc_config.svh"
`default_nettype none

package smc_pkg;

  // ------------------------------------------------------------
  // Vector types
  typedef logic [31:0]              haddr_t;     // AHB byte address
  typedef logic [`SMC_HDATA_W-1:0]  hdata_t;     // AHB data bus
  typedef logic [`SMC_EXT_AW-1:0]   ext_addr_t;  // External byte address
  typedef logic [`SMC_EXT_DW-1:0]   ext_byte_t;  // External data
  typedef logic [1:0]               xfer_size_t; // hsize[1:0]
  typedef logic [1:0]               lane_t;      // Byte index in word

  // ------------------------------------------------------------
  // AHB codes
  localparam logic [1:0] TRN_IDLE   = 2'b00;
  localparam logic [1:0] TRN_BUSY   = 2'b01;
  localparam logic [1:0] TRN_NONSEQ = 2'b10;
  localparam logic [1:0] TRN_SEQ    = 2'b11;

  localparam logic [2:0] SZ_BYTE = 3'b000;
  localparam logic [2:0] SZ_HALF = 3'b001;
  localparam logic [2:0] SZ_WORD = 3'b010;

  localparam logic [1:0] RSP_OKAY  = 2'b00;
  localparam logic [1:0] RSP_ERROR = 2'b01;

  // Byte access sequencer
  typedef enum logic [1:0] {ST_IDLE, ST_STROBE, ST_NEXT, ST_DONE} access_state_e;

endpackage

`default_nettype wire
